/* cpu_pkg.sv */
package cpu_pkg;

  // memory geometry
  localparam int ADDR_WIDTH = 6;
  // fixed by the instruction layout
  localparam int DATA_WIDTH = 16;
  localparam int FIELD_WIDTH = 3;

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [ADDR_WIDTH-1:0] addr_t;

  // first instruction lives here, cells below hold data
  localparam addr_t START_PC = addr_t'(8);

  // opcodes not listed here are skipped by the CPU
  typedef enum logic [3:0] {
    OP_MOV  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_MUL  = 4'd3,
    OP_IN   = 4'd7,
    OP_OUT  = 4'd8,
    OP_STOP = 4'd15
  } opcode_e;

  // one operand field, ind set means mem[addr] is the real address
  typedef struct packed {
    logic                   ind;
    logic [FIELD_WIDTH-1:0] addr;
  } operand_t;

  // instruction word
  // a is the destination, b and c are sources
  typedef struct packed {
    opcode_e  opcode;
    operand_t a;
    operand_t b;
    operand_t c;
  } instr_t;

  typedef enum logic [1:0] {
    ALU_ADD = 2'd0,
    ALU_SUB = 2'd1,
    ALU_MUL = 2'd2
  } alu_op_e;

  // request to the synchronous memory
  // read data shows up on mem_in one cycle after a read
  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t data;
  } mem_req_t;

  // convenience widths for the testbench side
  localparam int MEM_REQ_WIDTH = 1 + ADDR_WIDTH + DATA_WIDTH;
  localparam int INSTR_WIDTH = 4 * (1 + FIELD_WIDTH);

  // number of addressable words
  localparam int MEM_DEPTH = 1 << ADDR_WIDTH;

endpackage

/* data_reg.sv */
`timescale 1ns/10ps

module data_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ld,
  input  logic     cl,
  input  payload_t d,
  output payload_t q
);

  // clear has priority over load
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (cl) begin
      q <= '0;
    end else if (ld) begin
      q <= d;
    end
  end

  // the controller never asks for both in one cycle
  a_ld_cl_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ld && cl)
  );

endmodule

/* pc_counter.sv */
`timescale 1ns/10ps

module pc_counter #(
  parameter int             ADDR_WIDTH = cpu_pkg::ADDR_WIDTH,
  parameter cpu_pkg::addr_t START_PC   = cpu_pkg::START_PC
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           ld,
  input  logic           inc,
  output cpu_pkg::addr_t pc
);

  // ld restarts the program, inc steps past a fetched word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
    end else if (ld) begin
      pc <= START_PC;
    end else if (inc) begin
      // wraps at the top of memory
      pc <= pc + {{(ADDR_WIDTH-1){1'b0}}, 1'b1};
    end
  end

  // start load and fetch increment belong to different states
  a_ld_inc_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(ld && inc)
  );

endmodule

/* alu.sv */
`timescale 1ns/10ps

module alu #(
  parameter int DATA_WIDTH = cpu_pkg::DATA_WIDTH
) (
  input  cpu_pkg::alu_op_e op,
  input  cpu_pkg::word_t   a,
  input  cpu_pkg::word_t   b,
  output cpu_pkg::word_t   result
);

  // full product, only the low word is kept
  logic [2*DATA_WIDTH-1:0] product;

  assign product = a * b;

  // all results wrap modulo 2^DATA_WIDTH
  always_comb begin
    case (op)
      cpu_pkg::ALU_ADD: begin
        result = a + b;
      end
      cpu_pkg::ALU_SUB: begin
        result = a - b;
      end
      cpu_pkg::ALU_MUL: begin
        result = product[DATA_WIDTH-1:0];
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

/* cpu_ctrl.sv */
`timescale 1ns/10ps

module cpu_ctrl #(
  parameter int ADDR_WIDTH = cpu_pkg::ADDR_WIDTH,
  parameter int DATA_WIDTH = cpu_pkg::DATA_WIDTH
) (
  input  logic              clk,
  input  logic              rst_n,
  input  cpu_pkg::word_t    mem_in,
  input  cpu_pkg::word_t    in,
  input  cpu_pkg::instr_t   ir,
  input  cpu_pkg::word_t    al,
  input  cpu_pkg::word_t    result,
  input  cpu_pkg::addr_t    pc,
  output cpu_pkg::mem_req_t mem,
  output logic              ir_ld,
  output logic              ir_cl,
  output logic              al_ld,
  output logic              al_cl,
  output logic              al_from_alu,
  output logic              pc_ld,
  output logic              pc_inc,
  output cpu_pkg::alu_op_e  alu_op,
  output cpu_pkg::word_t    out,
  output logic              halted
);

  typedef enum logic [3:0] {
    S_START,
    S_FETCH,
    S_DECODE,
    S_IN_IND,
    S_OUT_READ,
    S_OUT_PTR,
    S_MOV_PTR,
    S_MOV_DATA,
    S_MOV_WPTR,
    S_OPB_PTR,
    S_OPB_LATCH,
    S_OPC_PTR,
    S_OPC_EXEC,
    S_RES_WPTR,
    S_HALT
  } state_e;

  state_e          state_q;
  state_e          state_d;
  cpu_pkg::word_t  out_d;
  cpu_pkg::word_t  out_q;
  // instruction word as it arrives from memory in decode
  cpu_pkg::instr_t dec;
  // indirect address is the read word cut to the address width
  cpu_pkg::addr_t  ptr;

  assign dec = cpu_pkg::instr_t'(mem_in);
  assign ptr = cpu_pkg::addr_t'(mem_in[ADDR_WIDTH-1:0]);
  assign out = out_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_START;
      out_q   <= {DATA_WIDTH{1'b0}};
    end else begin
      state_q <= state_d;
      out_q   <= out_d;
    end
  end

  assign halted = (state_q == S_HALT);

  // opcode of the held instruction picks the alu function
  always_comb begin
    case (ir.opcode)
      cpu_pkg::OP_SUB: alu_op = cpu_pkg::ALU_SUB;
      cpu_pkg::OP_MUL: alu_op = cpu_pkg::ALU_MUL;
      default:         alu_op = cpu_pkg::ALU_ADD;
    endcase
  end

  always_comb begin
    state_d     = state_q;
    out_d       = out_q;
    mem.we      = 1'b0;
    mem.addr    = '0;
    mem.data    = '0;
    ir_ld       = 1'b0;
    ir_cl       = 1'b0;
    al_ld       = 1'b0;
    al_cl       = 1'b0;
    al_from_alu = 1'b0;
    pc_ld       = 1'b0;
    pc_inc      = 1'b0;

    case (state_q)
      S_START: begin
        pc_ld   = 1'b1;
        ir_cl   = 1'b1;
        al_cl   = 1'b1;
        state_d = S_FETCH;
      end

      S_FETCH: begin
        mem.addr = pc;
        pc_inc   = 1'b1;
        state_d  = S_DECODE;
      end

      // word read in fetch is on mem_in now
      S_DECODE: begin
        ir_ld = 1'b1;
        case (dec.opcode)
          cpu_pkg::OP_IN: begin
            mem.addr = cpu_pkg::addr_t'(dec.a.addr);
            if (dec.a.ind) begin
              state_d = S_IN_IND;
            end else begin
              mem.we   = 1'b1;
              mem.data = in;
              state_d  = S_FETCH;
            end
          end
          cpu_pkg::OP_OUT: begin
            mem.addr = cpu_pkg::addr_t'(dec.a.addr);
            state_d  = dec.a.ind ? S_OUT_PTR : S_OUT_READ;
          end
          cpu_pkg::OP_MOV: begin
            mem.addr = cpu_pkg::addr_t'(dec.b.addr);
            state_d  = dec.b.ind ? S_MOV_PTR : S_MOV_DATA;
          end
          cpu_pkg::OP_ADD, cpu_pkg::OP_SUB, cpu_pkg::OP_MUL: begin
            mem.addr = cpu_pkg::addr_t'(dec.b.addr);
            state_d  = dec.b.ind ? S_OPB_PTR : S_OPB_LATCH;
          end
          cpu_pkg::OP_STOP: begin
            state_d = S_HALT;
          end
          default: begin
            // skip an unknown opcode
            state_d = S_FETCH;
          end
        endcase
      end

      S_IN_IND: begin
        mem.we   = 1'b1;
        mem.addr = ptr;
        mem.data = in;
        state_d  = S_FETCH;
      end

      S_OUT_PTR: begin
        mem.addr = ptr;
        state_d  = S_OUT_READ;
      end

      S_OUT_READ: begin
        out_d   = mem_in;
        state_d = S_FETCH;
      end

      S_MOV_PTR: begin
        mem.addr = ptr;
        state_d  = S_MOV_DATA;
      end

      // source word on mem_in
      S_MOV_DATA: begin
        mem.addr = cpu_pkg::addr_t'(ir.a.addr);
        if (ir.a.ind) begin
          al_ld   = 1'b1;
          state_d = S_MOV_WPTR;
        end else begin
          mem.we   = 1'b1;
          mem.data = mem_in;
          state_d  = S_FETCH;
        end
      end

      S_MOV_WPTR: begin
        mem.we   = 1'b1;
        mem.addr = ptr;
        mem.data = al;
        al_cl    = 1'b1;
        state_d  = S_FETCH;
      end

      S_OPB_PTR: begin
        mem.addr = ptr;
        state_d  = S_OPB_LATCH;
      end

      // mem[B] goes to al, then read C
      S_OPB_LATCH: begin
        al_ld    = 1'b1;
        mem.addr = cpu_pkg::addr_t'(ir.c.addr);
        state_d  = ir.c.ind ? S_OPC_PTR : S_OPC_EXEC;
      end

      S_OPC_PTR: begin
        mem.addr = ptr;
        state_d  = S_OPC_EXEC;
      end

      // al holds B, mem_in holds C
      S_OPC_EXEC: begin
        mem.addr = cpu_pkg::addr_t'(ir.a.addr);
        if (ir.a.ind) begin
          al_ld       = 1'b1;
          al_from_alu = 1'b1;
          state_d     = S_RES_WPTR;
        end else begin
          mem.we   = 1'b1;
          mem.data = result;
          state_d  = S_FETCH;
        end
      end

      S_RES_WPTR: begin
        mem.we   = 1'b1;
        mem.addr = ptr;
        mem.data = al;
        al_cl    = 1'b1;
        state_d  = S_FETCH;
      end

      S_HALT: begin
        state_d = S_HALT;
      end

      default: begin
        state_d = S_START;
      end
    endcase
  end

  // memory is left alone once the program ends
  a_no_write_halted: assert property (
    @(posedge clk) disable iff (!rst_n)
    halted |-> !mem.we
  );

  // halt is sticky and the program counter freezes with it
  a_halt_sticky: assert property (
    @(posedge clk) disable iff (!rst_n)
    halted |=> halted && $stable(pc)
  );

endmodule

/* cpu_top.sv */
`timescale 1ns/10ps

module cpu_top #(
  parameter int ADDR_WIDTH = cpu_pkg::ADDR_WIDTH,
  parameter int DATA_WIDTH = cpu_pkg::DATA_WIDTH
) (
  input  logic              clk,
  input  logic              rst_n,
  input  cpu_pkg::word_t    in,
  input  cpu_pkg::word_t    mem_in,
  output cpu_pkg::mem_req_t mem,
  output cpu_pkg::word_t    out,
  output cpu_pkg::addr_t    pc,
  output logic              halted
);

  cpu_pkg::instr_t  ir;
  cpu_pkg::word_t   al;
  cpu_pkg::word_t   al_d;
  cpu_pkg::word_t   result;
  cpu_pkg::alu_op_e alu_op;
  logic             ir_ld;
  logic             ir_cl;
  logic             al_ld;
  logic             al_cl;
  logic             al_from_alu;
  logic             pc_ld;
  logic             pc_inc;

  // al takes a memory word or an alu result
  assign al_d = al_from_alu ? result : mem_in;

  cpu_ctrl #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .DATA_WIDTH(DATA_WIDTH)
  ) ctrl_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_in     (mem_in),
    .in         (in),
    .ir         (ir),
    .al         (al),
    .result     (result),
    .pc         (pc),
    .mem        (mem),
    .ir_ld      (ir_ld),
    .ir_cl      (ir_cl),
    .al_ld      (al_ld),
    .al_cl      (al_cl),
    .al_from_alu(al_from_alu),
    .pc_ld      (pc_ld),
    .pc_inc     (pc_inc),
    .alu_op     (alu_op),
    .out        (out),
    .halted     (halted)
  );

  data_reg #(
    .payload_t(cpu_pkg::instr_t)
  ) ir_reg (
    .clk  (clk),
    .rst_n(rst_n),
    .ld   (ir_ld),
    .cl   (ir_cl),
    .d    (cpu_pkg::instr_t'(mem_in)),
    .q    (ir)
  );

  data_reg #(
    .payload_t(cpu_pkg::word_t)
  ) al_reg (
    .clk  (clk),
    .rst_n(rst_n),
    .ld   (al_ld),
    .cl   (al_cl),
    .d    (al_d),
    .q    (al)
  );

  pc_counter #(
    .ADDR_WIDTH(ADDR_WIDTH),
    .START_PC  (cpu_pkg::START_PC)
  ) pc_inst (
    .clk  (clk),
    .rst_n(rst_n),
    .ld   (pc_ld),
    .inc  (pc_inc),
    .pc   (pc)
  );

  alu #(
    .DATA_WIDTH(DATA_WIDTH)
  ) alu_inst (
    .op    (alu_op),
    .a     (al),
    .b     (mem_in),
    .result(result)
  );

endmodule

/* tb_mem.sv */
`timescale 1ns/10ps

module tb_mem #(
  parameter int DEPTH = cpu_pkg::MEM_DEPTH
) (
  input  logic              clk,
  input  cpu_pkg::mem_req_t req,
  output cpu_pkg::word_t    rd,
  input  logic              load,
  input  cpu_pkg::addr_t    load_addr,
  input  cpu_pkg::word_t    load_data
);

  cpu_pkg::word_t cells [DEPTH];

  // program load wins, the CPU sits in reset or halt while it runs
  always @(posedge clk) begin
    if (load) begin
      cells[load_addr] <= load_data;
    end else if (req.we) begin
      cells[req.addr] <= req.data;
    end
    // synchronous read, one cycle behind the address
    rd <= cells[req.addr];
  end

endmodule

/* cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;

  localparam int DEPTH = cpu_pkg::MEM_DEPTH;
  localparam int NUM_RANDOM = 16;
  localparam int NUM_PROGS = NUM_RANDOM + 1;
  // load, reset, 17 instructions at up to 8 cycles, halt window
  localparam int PROG_CYCLES = DEPTH + 2 + 16 + 8 * 17 + 24;
  localparam int CYCLE_LIMIT = NUM_PROGS * PROG_CYCLES + 200;
  localparam int CODE_BASE = int'(cpu_pkg::START_PC);

  logic              clk;
  logic              rst_n;
  cpu_pkg::word_t    in;
  cpu_pkg::word_t    mem_in;
  cpu_pkg::mem_req_t mem;
  cpu_pkg::word_t    out;
  cpu_pkg::addr_t    pc;
  logic              halted;
  logic              load;
  cpu_pkg::addr_t    load_addr;
  cpu_pkg::word_t    load_data;

  logic [31:0]       lfsr_state;
  int                cycle_count;
  logic              checking;
  cpu_pkg::word_t    prev_out;
  cpu_pkg::word_t    image [DEPTH];
  cpu_pkg::word_t    model_mem [DEPTH];
  cpu_pkg::mem_req_t exp_writes [$];
  cpu_pkg::word_t    exp_outs [$];
  cpu_pkg::word_t    exp_out_final;

  cpu_top #(
    .ADDR_WIDTH(cpu_pkg::ADDR_WIDTH),
    .DATA_WIDTH(cpu_pkg::DATA_WIDTH)
  ) cpu_top_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .in    (in),
    .mem_in(mem_in),
    .mem   (mem),
    .out   (out),
    .pc    (pc),
    .halted(halted)
  );

  tb_mem #(
    .DEPTH(DEPTH)
  ) mem_model (
    .clk      (clk),
    .req      (mem),
    .rd       (mem_in),
    .load     (load),
    .load_addr(load_addr),
    .load_data(load_data)
  );

  always #50 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count > CYCLE_LIMIT) begin
      abort_run("timeout: a program did not reach STOP in time");
    end
  end

  task automatic check_write(input cpu_pkg::mem_req_t got, input cpu_pkg::mem_req_t exp);
    if (got !== exp) begin
      $display("ERROR at %0t: mem got we=%b addr=%0d data=%h, expected we=%b addr=%0d data=%h",
               $time, got.we, got.addr, got.data, exp.we, exp.addr, exp.data);
      abort_run("memory write does not match the model");
    end
  endtask

  task automatic check_word(input cpu_pkg::word_t got, input cpu_pkg::word_t exp,
                            input string name);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %h, expected %h", $time, name, got, exp);
      abort_run("data word does not match the model");
    end
  endtask

  task automatic check_addr(input cpu_pkg::addr_t got, input cpu_pkg::addr_t exp,
                            input string name);
    if (got !== exp) begin
      $display("ERROR at %0t: %s got %0d, expected %0d", $time, name, got, exp);
      abort_run("address does not match the expected value");
    end
  endtask

  // galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  function automatic int take_bits(input int n);
    int v;
    int i;
    v = 0;
    for (i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic cpu_pkg::operand_t opnd(input logic ind, input int f);
    cpu_pkg::operand_t o;
    o.ind = ind;
    o.addr = 3'(f);
    return o;
  endfunction

  // destinations stay in 0..5, indirect always goes through cells 6 and 7
  function automatic cpu_pkg::operand_t rand_operand(input logic dest);
    logic ind;
    ind = 1'(take_bits(1));
    if (ind) begin
      return opnd(1'b1, 6 + take_bits(1));
    end else if (dest) begin
      return opnd(1'b0, take_bits(3) % 6);
    end
    return opnd(1'b0, take_bits(3));
  endfunction

  function automatic cpu_pkg::instr_t make_instr(input logic [3:0] op,
                                                 input cpu_pkg::operand_t a,
                                                 input cpu_pkg::operand_t b,
                                                 input cpu_pkg::operand_t c);
    cpu_pkg::instr_t ins;
    ins.opcode = cpu_pkg::opcode_e'(op);
    ins.a = a;
    ins.b = b;
    ins.c = c;
    return ins;
  endfunction

  task automatic fill_image();
    int i;
    for (i = 0; i < DEPTH; i++) begin
      image[i] = cpu_pkg::word_t'(16'hd000 + i);
    end
    for (i = 0; i < 6; i++) begin
      image[i] = cpu_pkg::word_t'(take_bits(16));
    end
    image[6] = cpu_pkg::word_t'(take_bits(3) % 6);
    image[7] = cpu_pkg::word_t'(take_bits(3) % 6);
  endtask

  // IN and OUT through every mode, one unknown opcode, then STOP
  task automatic build_fixed();
    fill_image();
    image[6] = 16'd1;
    image[7] = 16'd4;
    image[CODE_BASE + 0] = make_instr(cpu_pkg::OP_IN, opnd(0, 2), opnd(0, 0), opnd(0, 0));
    image[CODE_BASE + 1] = make_instr(cpu_pkg::OP_OUT, opnd(0, 2), opnd(0, 0), opnd(0, 0));
    image[CODE_BASE + 2] = make_instr(cpu_pkg::OP_IN, opnd(1, 6), opnd(0, 0), opnd(0, 0));
    image[CODE_BASE + 3] = make_instr(cpu_pkg::OP_OUT, opnd(1, 6), opnd(0, 0), opnd(0, 0));
    image[CODE_BASE + 4] = make_instr(cpu_pkg::OP_OUT, opnd(1, 7), opnd(0, 0), opnd(0, 0));
    image[CODE_BASE + 5] = make_instr(cpu_pkg::OP_IN, opnd(1, 7), opnd(0, 0), opnd(0, 0));
    image[CODE_BASE + 6] = make_instr(cpu_pkg::OP_OUT, opnd(0, 4), opnd(0, 0), opnd(0, 0));
    image[CODE_BASE + 7] = make_instr(4'd5, opnd(0, 1), opnd(0, 2), opnd(0, 3));
    image[CODE_BASE + 8] = make_instr(cpu_pkg::OP_STOP, opnd(0, 0), opnd(0, 0), opnd(0, 0));
  endtask

  task automatic build_random();
    int i;
    int len;
    int sel;
    logic [3:0] op;
    cpu_pkg::operand_t oa;
    cpu_pkg::operand_t ob;
    cpu_pkg::operand_t oc;
    fill_image();
    len = 1 + take_bits(4);
    for (i = 0; i < len; i++) begin
      sel = take_bits(3);
      case (sel)
        1: op = cpu_pkg::OP_ADD;
        2: op = cpu_pkg::OP_SUB;
        3: op = cpu_pkg::OP_MUL;
        4: op = cpu_pkg::OP_IN;
        5: op = cpu_pkg::OP_OUT;
        6: begin
          // opcodes the CPU does not know
          sel = take_bits(2);
          op = (sel == 3) ? 4'd12 : 4'(4 + sel);
        end
        default: op = cpu_pkg::OP_MOV;
      endcase
      oa = rand_operand(op != cpu_pkg::OP_OUT);
      ob = rand_operand(1'b0);
      oc = rand_operand(1'b0);
      image[CODE_BASE + i] = make_instr(op, oa, ob, oc);
    end
    image[CODE_BASE + len] = make_instr(cpu_pkg::OP_STOP, opnd(0, 0), opnd(0, 0), opnd(0, 0));
  endtask

  function automatic cpu_pkg::addr_t resolve(input cpu_pkg::operand_t o);
    if (o.ind) begin
      return cpu_pkg::addr_t'(model_mem[o.addr]);
    end
    return cpu_pkg::addr_t'(o.addr);
  endfunction

  function automatic void model_write(input cpu_pkg::addr_t a, input cpu_pkg::word_t v);
    cpu_pkg::mem_req_t r;
    r.we = 1'b1;
    r.addr = a;
    r.data = v;
    model_mem[a] = v;
    exp_writes.push_back(r);
  endfunction

  // instruction set model, out updates are kept only where the value changes
  function automatic void run_model(input cpu_pkg::word_t in_val);
    cpu_pkg::addr_t  pc_m;
    cpu_pkg::instr_t ins;
    cpu_pkg::word_t  vb;
    cpu_pkg::word_t  vc;
    cpu_pkg::word_t  last_out;
    logic            stop;
    int              step;
    for (step = 0; step < DEPTH; step++) begin
      model_mem[step] = image[step];
    end
    exp_writes.delete();
    exp_outs.delete();
    pc_m = cpu_pkg::START_PC;
    last_out = '0;
    stop = 1'b0;
    for (step = 0; step < DEPTH && !stop; step++) begin
      ins = cpu_pkg::instr_t'(model_mem[pc_m]);
      pc_m = pc_m + 1'b1;
      vb = model_mem[resolve(ins.b)];
      vc = model_mem[resolve(ins.c)];
      case (ins.opcode)
        cpu_pkg::OP_IN: model_write(resolve(ins.a), in_val);
        cpu_pkg::OP_OUT: begin
          vb = model_mem[resolve(ins.a)];
          if (vb != last_out) begin
            exp_outs.push_back(vb);
          end
          last_out = vb;
        end
        cpu_pkg::OP_MOV: model_write(resolve(ins.a), vb);
        cpu_pkg::OP_ADD: model_write(resolve(ins.a), cpu_pkg::word_t'(vb + vc));
        cpu_pkg::OP_SUB: model_write(resolve(ins.a), cpu_pkg::word_t'(vb - vc));
        cpu_pkg::OP_MUL: model_write(resolve(ins.a), cpu_pkg::word_t'(vb * vc));
        cpu_pkg::OP_STOP: stop = 1'b1;
        default: ;
      endcase
    end
    exp_out_final = last_out;
  endfunction

  // write stream and out updates, sampled away from the rising edge
  always @(negedge clk) begin
    if (checking && rst_n) begin
      if (mem.we === 1'b1) begin
        if (exp_writes.size() == 0) begin
          abort_run("the CPU wrote memory where the model makes no write");
        end else begin
          check_write(mem, exp_writes.pop_front());
        end
      end
      if (out !== prev_out) begin
        if (exp_outs.size() == 0) begin
          abort_run("out changed where the model expects no new value");
        end else begin
          check_word(out, exp_outs.pop_front(), "out");
        end
        prev_out = out;
      end
    end
  end

  task automatic run_program();
    cpu_pkg::addr_t pc_hold;
    int i;
    checking = 1'b0;
    for (i = 0; i < DEPTH; i++) begin
      @(posedge clk);
      #1;
      load = 1'b1;
      load_addr = cpu_pkg::addr_t'(i);
      load_data = image[i];
    end
    @(posedge clk);
    #1;
    load = 1'b0;
    rst_n = 1'b0;
    in = cpu_pkg::word_t'(take_bits(16));
    run_model(in);
    prev_out = '0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    checking = 1'b1;
    // start cycle
    @(negedge clk);
    if (mem.we !== 1'b0 || halted !== 1'b0) begin
      abort_run("write strobe or halted is set right after reset");
    end
    check_word(out, '0, "out");
    // first fetch
    @(negedge clk);
    check_addr(pc, cpu_pkg::START_PC, "pc");
    check_addr(mem.addr, cpu_pkg::START_PC, "mem.addr");
    while (halted !== 1'b1) begin
      @(negedge clk);
    end
    pc_hold = pc;
    repeat (20) begin
      @(negedge clk);
      if (halted !== 1'b1) begin
        abort_run("halted dropped after STOP");
      end
      check_addr(pc, pc_hold, "pc");
    end
    if (exp_writes.size() != 0) begin
      abort_run("the CPU halted before making every write of the model");
    end
    if (exp_outs.size() != 0) begin
      abort_run("the CPU halted before showing every out value of the model");
    end
    check_word(out, exp_out_final, "out");
    for (i = 0; i < 8; i++) begin
      check_word(mem_model.cells[i], model_mem[i], $sformatf("mem[%0d]", i));
    end
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    in = '0;
    load = 1'b0;
    load_addr = '0;
    load_data = '0;
    checking = 1'b0;
    prev_out = '0;
    cycle_count = 0;
    lfsr_state = 32'h476b6dc5;
    build_fixed();
    run_program();
    repeat (NUM_RANDOM) begin
      build_random();
      run_program();
    end
    $display("Testbench passed");
    $finish;
  end

endmodule

/* files.f */
cpu_pkg.sv
data_reg.sv
pc_counter.sv
alu.sv
cpu_ctrl.sv
cpu_top.sv
tb_mem.sv
cpu_tb.sv
